/* alu_station.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module alu_station (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    rs_load,
    input  wire ooo_core_pkg::rs_entry_t rs_entry,
    input  wire ooo_core_pkg::cdb_t      cdb,
    output logic                         rs_full,
    output logic                         issue,
    output ooo_core_pkg::rs_entry_t      issue_entry
);

    localparam int IDX_W = $clog2(`RS_DEPTH);

    ooo_core_pkg::rs_entry_t entries [`RS_DEPTH];
    logic [`RS_DEPTH-1:0]    valid;
    logic [`RS_DEPTH-1:0]    ready;      // both operands captured
    logic [IDX_W-1:0]        load_idx;
    logic [IDX_W-1:0]        issue_idx;

    assign rs_full = &valid;

    ////////////////////
    // select
    ////////////////////

    always_comb begin
        load_idx  = '0;
        issue_idx = '0;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready[i] = valid[i] && entries[i].a.ready && entries[i].b.ready;
        end
        // walk down so lowest index ends up chosen
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) load_idx = IDX_W'(i);
            if (ready[i])  issue_idx = IDX_W'(i);
        end
    end

    assign issue       = |ready;
    assign issue_entry = entries[issue_idx];

    ////////////////////
    // entries
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (issue)   valid[issue_idx] <= 1'b0;   // slot frees on issue
            if (rs_load) valid[load_idx]  <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            // cdb wakeup, either operand
            if (cdb.valid && !entries[i].a.ready && entries[i].a.tag == cdb.tag) begin
                entries[i].a.ready <= 1'b1;
                entries[i].a.value <= cdb.value;
            end
            if (cdb.valid && !entries[i].b.ready && entries[i].b.tag == cdb.tag) begin
                entries[i].b.ready <= 1'b1;
                entries[i].b.value <= cdb.value;
            end
        end
        if (rs_load) entries[load_idx] <= rs_entry;   // bypass done in dispatch
    end

    // dispatch honours rs_full
    no_load_when_full: assert property (@(posedge clock) disable iff (reset)
        rs_load |-> !rs_full);

endmodule

`default_nettype wire

/* arch_regfile.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module arch_regfile (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire ooo_core_pkg::commit_t commit,
    input  wire logic [`REG_IDX_W-1:0] rf_idx_a,
    input  wire logic [`REG_IDX_W-1:0] rf_idx_b,
    output logic [`XLEN-1:0]           rf_a,
    output logic [`XLEN-1:0]           rf_b
);

    logic [`XLEN-1:0] regs [`ARCH_REGS];

    // retired state only, x0 never written
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.data;
        end
    end

    assign rf_a = regs[rf_idx_a];   // no write bypass, rob covers it
    assign rf_b = regs[rf_idx_b];

endmodule

`default_nettype wire

/* inst_decoder.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module inst_decoder (
    input  wire logic                     inst_valid,
    input  wire ooo_core_pkg::inst_word_u inst_word,
    output ooo_core_pkg::dec_inst_t       dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = inst_word.r_fmt.opcode;   // same bits in both views
    assign funct3 = inst_word.r_fmt.funct3;

    always_comb begin
        dec     = '0;
        dec.rd  = inst_word.r_fmt.rd;
        dec.rs1 = inst_word.r_fmt.rs1;

        // funct3 decode shared by both forms
        case (funct3)
            3'b111:  dec.op = ooo_core_pkg::ALU_AND;
            3'b110:  dec.op = ooo_core_pkg::ALU_OR;
            3'b100:  dec.op = ooo_core_pkg::ALU_XOR;
            3'b010:  dec.op = ooo_core_pkg::ALU_SLT;
            3'b001:  dec.op = ooo_core_pkg::ALU_SLL;
            3'b101:  dec.op = ooo_core_pkg::ALU_SRL;
            default: dec.op = ooo_core_pkg::ALU_ADD;
        endcase

        if (opcode == `OPCODE_OP) begin
            dec.valid = inst_valid;
            dec.rs2   = inst_word.r_fmt.rs2;
            if (funct3 == 3'b000 && inst_word.r_fmt.funct7[5]) begin
                dec.op = ooo_core_pkg::ALU_SUB;
            end
        end else if (opcode == `OPCODE_OP_IMM) begin
            dec.valid    = inst_valid;
            dec.uses_imm = 1'b1;
            dec.imm      = {{(`XLEN-12){inst_word.i_fmt.imm12[11]}}, inst_word.i_fmt.imm12};
        end
    end

endmodule

`default_nettype wire

/* int_alu.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module int_alu (
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    issue,
    input  wire ooo_core_pkg::rs_entry_t issue_entry,
    output ooo_core_pkg::cdb_t           cdb
);

    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;

    assign a     = issue_entry.a.value;
    assign b     = issue_entry.b.value;
    assign shamt = b[4:0];               // rv32i uses low 5 bits only

    always_comb begin
        case (issue_entry.op)
            ooo_core_pkg::ALU_SUB: result = a - b;
            ooo_core_pkg::ALU_AND: result = a & b;
            ooo_core_pkg::ALU_OR:  result = a | b;
            ooo_core_pkg::ALU_XOR: result = a ^ b;
            ooo_core_pkg::ALU_SLT: result = `XLEN'($signed(a) < $signed(b));
            ooo_core_pkg::ALU_SLL: result = a << shamt;
            ooo_core_pkg::ALU_SRL: result = a >> shamt;   // logical
            default:               result = a + b;
        endcase
    end

    // output register is the cdb
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue;
        end
        if (issue) begin
            cdb.tag   <= issue_entry.tag;
            cdb.value <= result;
        end
    end

endmodule

`default_nettype wire

/* ooo_core.f */
+incdir+.
ooo_core_pkg.sv
inst_decoder.sv
rename_dispatch.sv
alu_station.sv
int_alu.sv
reorder_buffer.sv
arch_regfile.sv
ooo_core.sv
tb_ooo_core.sv

/* ooo_core.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module ooo_core (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire logic                     inst_valid,
    input  wire ooo_core_pkg::inst_word_u inst_word,
    output logic                          stall,
    output ooo_core_pkg::commit_t         commit
);

    ooo_core_pkg::dec_inst_t   dec;
    ooo_core_pkg::rs_entry_t   rs_entry;
    ooo_core_pkg::rs_entry_t   issue_entry;
    ooo_core_pkg::rob_lookup_t lookup_a;
    ooo_core_pkg::rob_lookup_t lookup_b;
    ooo_core_pkg::cdb_t        cdb;              // alu output register
    logic                      rs_load;
    logic                      rs_full;
    logic                      issue;
    logic                      rob_alloc;
    logic                      rob_full;
    logic [`ROB_TAG_W-1:0]     alloc_tag;
    logic [`ROB_TAG_W-1:0]     lookup_tag_a;
    logic [`ROB_TAG_W-1:0]     lookup_tag_b;
    logic [`REG_IDX_W-1:0]     alloc_rd;
    logic [`REG_IDX_W-1:0]     rf_idx_a;
    logic [`REG_IDX_W-1:0]     rf_idx_b;
    logic [`XLEN-1:0]          rf_a;
    logic [`XLEN-1:0]          rf_b;

    ////////////////////
    // front end
    ////////////////////

    inst_decoder i_decoder (
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .dec        (dec)
    );

    rename_dispatch i_dispatch (
        .clock        (clock),
        .reset        (reset),
        .dec          (dec),
        .rs_full      (rs_full),
        .rob_full     (rob_full),
        .alloc_tag    (alloc_tag),
        .lookup_a     (lookup_a),
        .lookup_b     (lookup_b),
        .rf_a         (rf_a),
        .rf_b         (rf_b),
        .cdb          (cdb),
        .commit       (commit),
        .stall        (stall),
        .rs_load      (rs_load),
        .rs_entry     (rs_entry),
        .rob_alloc    (rob_alloc),
        .alloc_rd     (alloc_rd),
        .lookup_tag_a (lookup_tag_a),
        .lookup_tag_b (lookup_tag_b),
        .rf_idx_a     (rf_idx_a),
        .rf_idx_b     (rf_idx_b)
    );

    ////////////////////
    // issue, execute
    ////////////////////

    alu_station i_station (
        .clock       (clock),
        .reset       (reset),
        .rs_load     (rs_load),
        .rs_entry    (rs_entry),
        .cdb         (cdb),
        .rs_full     (rs_full),
        .issue       (issue),
        .issue_entry (issue_entry)
    );

    int_alu i_alu (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .issue_entry (issue_entry),
        .cdb         (cdb)
    );

    ////////////////////
    // retire
    ////////////////////

    reorder_buffer i_rob (
        .clock        (clock),
        .reset        (reset),
        .rob_alloc    (rob_alloc),
        .alloc_rd     (alloc_rd),
        .cdb          (cdb),
        .lookup_tag_a (lookup_tag_a),
        .lookup_tag_b (lookup_tag_b),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .lookup_a     (lookup_a),
        .lookup_b     (lookup_b),
        .commit       (commit)
    );

    arch_regfile i_regfile (
        .clock    (clock),
        .reset    (reset),
        .commit   (commit),
        .rf_idx_a (rf_idx_a),
        .rf_idx_b (rf_idx_b),
        .rf_a     (rf_a),
        .rf_b     (rf_b)
    );

endmodule

`default_nettype wire

/* ooo_core_pkg.sv */
`include "ooo_core_settings.svh"
`default_nettype none

package ooo_core_pkg;

    ////////////////////
    // instruction word
    ////////////////////

    // same 32 bits, register view or immediate view
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;   // bit 5 picks sub
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } r_fmt;
        struct packed {
            logic [11:0]           imm12;    // sign extended in decode
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } i_fmt;
    } inst_word_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    ////////////////////
    // pipeline payloads
    ////////////////////

    typedef struct packed {
        logic                  valid;
        alu_op_e               op;
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic                  uses_imm;   // b comes from imm, not rs2
        logic [`XLEN-1:0]      imm;
    } dec_inst_t;

    // ready means value holds data, else wait on tag
    typedef struct packed {
        logic                  ready;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      value;
    } operand_t;

    typedef struct packed {
        alu_op_e               op;
        logic [`ROB_TAG_W-1:0] tag;        // destination rob slot
        operand_t              a;
        operand_t              b;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_TAG_W-1:0] tag;
        logic [`XLEN-1:0]      value;
    } cdb_t;

    typedef struct packed {
        logic                  done;
        logic [`XLEN-1:0]      value;
    } rob_lookup_t;

    typedef struct packed {
        logic                  valid;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      data;
    } commit_t;

endpackage

`default_nettype wire

/* ooo_core_settings.svh */
`ifndef OOO_CORE_SETTINGS_SVH
`define OOO_CORE_SETTINGS_SVH

////////////////////
// datapath
////////////////////
`define XLEN          32
`define ARCH_REGS     32
`define REG_IDX_W     5      // log2 of ARCH_REGS

////////////////////
// window sizes
////////////////////
`define ROB_DEPTH     8      // power of two, pointers wrap for free
`define ROB_TAG_W     3
`define RS_DEPTH      4

////////////////////
// rv32i opcodes
////////////////////
`define OPCODE_OP     7'b0110011   // add sub and or xor slt sll srl
`define OPCODE_OP_IMM 7'b0010011   // addi andi ori xori slti

`endif

/* rename_dispatch.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module rename_dispatch (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire ooo_core_pkg::dec_inst_t   dec,
    input  wire logic                      rs_full,
    input  wire logic                      rob_full,
    input  wire logic [`ROB_TAG_W-1:0]     alloc_tag,
    input  wire ooo_core_pkg::rob_lookup_t lookup_a,
    input  wire ooo_core_pkg::rob_lookup_t lookup_b,
    input  wire logic [`XLEN-1:0]          rf_a,
    input  wire logic [`XLEN-1:0]          rf_b,
    input  wire ooo_core_pkg::cdb_t        cdb,
    input  wire ooo_core_pkg::commit_t     commit,
    output logic                           stall,
    output logic                           rs_load,
    output ooo_core_pkg::rs_entry_t        rs_entry,
    output logic                           rob_alloc,
    output logic [`REG_IDX_W-1:0]          alloc_rd,
    output logic [`ROB_TAG_W-1:0]          lookup_tag_a,
    output logic [`ROB_TAG_W-1:0]          lookup_tag_b,
    output logic [`REG_IDX_W-1:0]          rf_idx_a,
    output logic [`REG_IDX_W-1:0]          rf_idx_b
);

    logic [`ARCH_REGS-1:0] map_busy;                  // value still in flight
    logic [`ROB_TAG_W-1:0] map_tag [`ARCH_REGS];
    logic [`ROB_TAG_W-1:0] retire_tag;                // follows the rob head
    logic                  dispatch;

    // regfile unless renamed, then rob done value, then cdb bypass
    function automatic ooo_core_pkg::operand_t source_op(
        input logic                      busy,
        input logic [`ROB_TAG_W-1:0]     tag,
        input ooo_core_pkg::rob_lookup_t found,
        input logic [`XLEN-1:0]          rf_value,
        input ooo_core_pkg::cdb_t        bus
    );
        ooo_core_pkg::operand_t op;
        op.ready = 1'b1;
        op.tag   = tag;
        op.value = rf_value;
        if (busy) begin
            if (found.done) begin
                op.value = found.value;
            end else if (bus.valid && bus.tag == tag) begin
                op.value = bus.value;               // result lands this edge
            end else begin
                op.ready = 1'b0;                    // wait for wakeup
                op.value = '0;
            end
        end
        return op;
    endfunction

    assign stall        = rob_full || rs_full;
    assign dispatch     = dec.valid && !stall;
    assign rs_load      = dispatch;
    assign rob_alloc    = dispatch;
    assign alloc_rd     = dec.rd;
    assign lookup_tag_a = map_tag[dec.rs1];
    assign lookup_tag_b = map_tag[dec.rs2];
    assign rf_idx_a     = dec.rs1;
    assign rf_idx_b     = dec.rs2;

    always_comb begin
        rs_entry.op  = dec.op;
        rs_entry.tag = alloc_tag;
        rs_entry.a   = source_op(map_busy[dec.rs1], map_tag[dec.rs1], lookup_a, rf_a, cdb);
        if (dec.uses_imm) begin
            rs_entry.b.ready = 1'b1;
            rs_entry.b.tag   = '0;
            rs_entry.b.value = dec.imm;
        end else begin
            rs_entry.b = source_op(map_busy[dec.rs2], map_tag[dec.rs2], lookup_b, rf_b, cdb);
        end
    end

    ////////////////////
    // map table
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            map_busy   <= '0;
            retire_tag <= '0;
        end else begin
            if (commit.valid) begin
                retire_tag <= retire_tag + 1'b1;
                // only if no younger writer took the register since
                if (map_tag[commit.rd] == retire_tag) begin
                    map_busy[commit.rd] <= 1'b0;
                end
            end
            if (dispatch && dec.rd != '0) begin
                map_busy[dec.rd] <= 1'b1;          // new mapping wins over retire
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch && dec.rd != '0) begin
            map_tag[dec.rd] <= alloc_tag;
        end
    end

    // a busy mapping names a live rob slot, never the free tail
    wait_tag_not_alloc: assert property (@(posedge clock) disable iff (reset)
        rs_load |-> (rs_entry.a.ready || rs_entry.a.tag != alloc_tag)
                 && (rs_entry.b.ready || rs_entry.b.tag != alloc_tag));

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module reorder_buffer (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  rob_alloc,
    input  wire logic [`REG_IDX_W-1:0] alloc_rd,
    input  wire ooo_core_pkg::cdb_t    cdb,
    input  wire logic [`ROB_TAG_W-1:0] lookup_tag_a,
    input  wire logic [`ROB_TAG_W-1:0] lookup_tag_b,
    output logic [`ROB_TAG_W-1:0]      alloc_tag,
    output logic                       rob_full,
    output ooo_core_pkg::rob_lookup_t  lookup_a,
    output ooo_core_pkg::rob_lookup_t  lookup_b,
    output ooo_core_pkg::commit_t      commit
);

    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] done;                   // result written by cdb
    logic [`REG_IDX_W-1:0] rd_q    [`ROB_DEPTH];
    logic [`XLEN-1:0]      value_q [`ROB_DEPTH];
    logic [`ROB_TAG_W-1:0] head;
    logic [`ROB_TAG_W-1:0] tail;
    logic [`ROB_TAG_W:0]   count;                  // one extra bit for full
    logic                  retire;

    assign alloc_tag = tail;
    assign rob_full  = count == `ROB_DEPTH;
    assign retire    = busy[head] && done[head];   // in order, one per cycle

    always_comb begin
        commit.valid = retire;
        commit.rd    = rd_q[head];
        commit.data  = (rd_q[head] == '0) ? '0 : value_q[head];   // x0 reads zero
        lookup_a.done  = done[lookup_tag_a];
        lookup_a.value = value_q[lookup_tag_a];
        lookup_b.done  = done[lookup_tag_b];
        lookup_b.value = value_q[lookup_tag_b];
    end

    ////////////////////
    // pointers, status
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;          // wraps at depth
            end
            if (cdb.valid) done[cdb.tag] <= 1'b1;
            if (rob_alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            case ({rob_alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rob_alloc) rd_q[tail]    <= alloc_rd;
        if (cdb.valid) value_q[cdb.tag] <= cdb.value;
    end

    // alu only completes work that is still in flight
    cdb_hits_live_entry: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> busy[cdb.tag] && !done[cdb.tag]);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile the ooo_core testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ooo_core -f ooo_core.f
./obj_dir/Vtb_ooo_core

/* tb_ooo_core.sv */
`include "ooo_core_settings.svh"
`default_nettype none

module tb_ooo_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_INST     = 400;
    localparam int WATCHDOG_NS  = (NUM_INST * 20 + RESET_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1

    logic                     clock = 1'b0;
    logic                     reset;
    logic                     inst_valid;
    ooo_core_pkg::inst_word_u inst_word;
    logic                     stall;
    ooo_core_pkg::commit_t    commit;

    logic [31:0]              lfsr_state = 32'h8633_5894;
    logic [31:0]              model_regs [32];          // software register file
    ooo_core_pkg::inst_word_u pending [$];              // accepted and not yet retired
    ooo_core_pkg::commit_t    expected;
    int                       sent         = 0;
    int                       commit_count = 0;
    logic                     stall_seen   = 1'b0;      // back-pressure reached

    ooo_core i_dut (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .stall      (stall),
        .commit     (commit)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    ////////////////////
    // helpers
    ////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("ERR %s got %h expected %h", name, got, want));
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);   // galois form shifting right
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    function automatic ooo_core_pkg::inst_word_u encode_r(
        input logic [6:0] funct7, input logic [4:0] rs2, input logic [4:0] rs1,
        input logic [2:0] funct3, input logic [4:0] rd);
        ooo_core_pkg::inst_word_u w;
        w.r_fmt.funct7 = funct7;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = funct3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = `OPCODE_OP;
        return w;
    endfunction

    function automatic ooo_core_pkg::inst_word_u encode_i(
        input logic [11:0] imm12, input logic [4:0] rs1, input logic [2:0] funct3,
        input logic [4:0] rd);
        ooo_core_pkg::inst_word_u w;
        w.i_fmt.imm12  = imm12;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = funct3;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = `OPCODE_OP_IMM;
        return w;
    endfunction

    // registers x0..x7 only so operands collide often
    function automatic ooo_core_pkg::inst_word_u random_inst();
        logic [3:0]               sel;
        logic [4:0]               rd;
        logic [4:0]               rs1;
        logic [4:0]               rs2;
        logic [11:0]              imm;
        ooo_core_pkg::inst_word_u w;
        sel = 4'(take_bits(4));
        rd  = 5'(take_bits(3));
        rs1 = 5'(take_bits(3));
        rs2 = 5'(take_bits(3));
        imm = 12'(take_bits(12));
        case (sel)
            4'd0:        w = encode_r(7'h00, rs2, rs1, 3'b000, rd);   // add
            4'd1:        w = encode_r(7'h20, rs2, rs1, 3'b000, rd);   // sub
            4'd2:        w = encode_r(7'h00, rs2, rs1, 3'b111, rd);   // and
            4'd3:        w = encode_r(7'h00, rs2, rs1, 3'b110, rd);   // or
            4'd4:        w = encode_r(7'h00, rs2, rs1, 3'b100, rd);   // xor
            4'd5, 4'd13: w = encode_r(7'h00, rs2, rs1, 3'b010, rd);   // slt
            4'd6, 4'd14: w = encode_r(7'h00, rs2, rs1, 3'b001, rd);   // sll
            4'd8:        w = encode_i(imm, rs1, 3'b000, rd);          // addi
            4'd9:        w = encode_i(imm, rs1, 3'b111, rd);          // andi
            4'd10:       w = encode_i(imm, rs1, 3'b110, rd);          // ori
            4'd11:       w = encode_i(imm, rs1, 3'b100, rd);          // xori
            4'd12:       w = encode_i(imm, rs1, 3'b010, rd);          // slti
            default:     w = encode_r(7'h00, rs2, rs1, 3'b101, rd);   // srl
        endcase
        return w;
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // in-order rv32i semantics on model_regs
    function automatic ooo_core_pkg::commit_t model_execute(
        input ooo_core_pkg::inst_word_u w);
        ooo_core_pkg::commit_t res;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           value;
        logic                  reg_form;
        reg_form = (w.r_fmt.opcode == `OPCODE_OP);
        a = model_regs[w.r_fmt.rs1];
        if (reg_form) begin
            b = model_regs[w.r_fmt.rs2];
        end else begin
            b = {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
        end
        case (w.r_fmt.funct3)
            3'b000:  value = (reg_form && w.r_fmt.funct7[5]) ? a - b : a + b;
            3'b111:  value = a & b;
            3'b110:  value = a | b;
            3'b100:  value = a ^ b;
            3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b001:  value = a << b[4:0];
            3'b101:  value = a >> b[4:0];
            default: value = '0;          // never sent
        endcase
        if (w.r_fmt.rd != 5'd0) model_regs[w.r_fmt.rd] = value;
        res.valid = 1'b1;
        res.rd    = w.r_fmt.rd;
        res.data  = (w.r_fmt.rd == 5'd0) ? 32'd0 : value;
        return res;
    endfunction

    // hold the word until an edge with stall low takes it
    task automatic send_inst(input ooo_core_pkg::inst_word_u w);
        logic taken;
        inst_valid = 1'b1;
        inst_word  = w;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clock);
            taken = !stall;               // stall is settled here
            if (stall) stall_seen = 1'b1;
            @(posedge clock);
            #1;
        end
        pending.push_back(w);
        sent++;
    endtask

    ////////////////////
    // compare on retire
    ////////////////////

    always @(negedge clock) begin
        if (!reset && commit.valid) begin
            if (pending.size() == 0) begin
                abort_run("commit reported with no instruction outstanding");
            end else begin
                expected = model_execute(pending.pop_front());
                compare_value("commit.rd", 32'(commit.rd), 32'(expected.rd));
                compare_value("commit.data", commit.data, expected.data);
                commit_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all instructions committed");
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst_word  = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        compare_value("stall", 32'(stall), 32'd0);             // quiet after reset
        compare_value("commit.valid", 32'(commit.valid), 32'd0);
        @(posedge clock);
        #1;

        // negative values, wide shifts, x0 target, dependent chain
        send_inst(encode_i(12'hffb, 5'd0, 3'b000, 5'd1));       // addi x1, x0, -5
        send_inst(encode_i(12'd37, 5'd0, 3'b000, 5'd2));        // low 5 bits shift by 5
        send_inst(encode_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));   // sll
        send_inst(encode_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd4));   // srl with zero fill
        send_inst(encode_r(7'h00, 5'd0, 5'd1, 3'b010, 5'd5));   // slt -5 < 0
        send_inst(encode_i(12'hffc, 5'd1, 3'b010, 5'd6));       // slti -5 < -4
        send_inst(encode_r(7'h20, 5'd1, 5'd0, 3'b000, 5'd7));   // sub x7, x0, x1
        send_inst(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));   // add into x0
        send_inst(encode_r(7'h00, 5'd7, 5'd0, 3'b000, 5'd3));   // reads x0
        send_inst(encode_i(12'hfff, 5'd3, 3'b100, 5'd3));
        send_inst(encode_i(12'h0f0, 5'd3, 3'b111, 5'd4));
        send_inst(encode_i(12'h700, 5'd4, 3'b110, 5'd5));
        send_inst(encode_r(7'h00, 5'd1, 5'd7, 3'b010, 5'd6));   // 5 < -5 false
        send_inst(encode_r(7'h00, 5'd4, 5'd5, 3'b111, 5'd2));

        // random program mostly back to back
        while (sent < NUM_INST) begin
            send_inst(random_inst());
            if (take_bits(3) == 32'd0) begin
                inst_valid = 1'b0;        // idle cycle now and then
                @(posedge clock);
                #1;
            end
        end
        inst_valid = 1'b0;

        wait (commit_count == NUM_INST);
        repeat (20) @(posedge clock);     // room for a stray extra commit
        if (!stall_seen) begin
            abort_run("stall never rose although the burst overran the ROB");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
